// ==== compile.f ====
+incdir+.
usiPkg.sv
ultraSimpleInterface.sv
usiGpioCsr.sv
usiPwmCsr.sv
usiSubsystem.sv
usiSubsystemTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the subsystem testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f compile.f --top-module usiSubsystemTb \
	-o simv > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Build failed"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "ALL TESTS PASSED" sim.log; then
	echo "Simulation passed"
	exit 0
fi
echo "Simulation failed"
exit 1

// ==== usiSubsystemTb.sv ====
// Directed testbench for the UltraSimple peripheral subsystem
// Acts as the bus master, drives inputs on the falling clock edge and checks
// read words, pin levels and ready levels against the CSR rules
`include "usi_consts.svh"
`default_nettype none

module usiSubsystemTb;

	timeunit 1ns;
	timeprecision 1ps;

	import usiPkg::*;

	localparam logic [7:0] lpGpio = `USI_GPIO_MAP;
	localparam logic [7:0] lpPwm  = `USI_PWM_MAP;

	logic                       iUsiClk;
	logic                       rst;
	usiBusCmdT                  mUsiCmd;
	logic [`USI_DATA_BIT-1:0]   mUsiRd;
	logic [`USI_SLAVE_NUM-1:0]  mUsiVd;
	logic [`USI_GPIO_WIDTH-1:0] gpioIn;
	logic [`USI_GPIO_WIDTH-1:0] gpioOut;
	logic [`USI_GPIO_WIDTH-1:0] gpioDir;
	logic                       pwmOut;
	int                         seed;		// Random traffic seed

	usiSubsystem dut_i
	(
		.iUsiClk (iUsiClk),
		.rst     (rst),
		.mUsiCmd (mUsiCmd),
		.mUsiRd  (mUsiRd),
		.mUsiVd  (mUsiVd),
		.gpioIn  (gpioIn),
		.gpioOut (gpioOut),
		.gpioDir (gpioDir),
		.pwmOut  (pwmOut)
	);

	// 4 ns clock
	initial
	begin
		iUsiClk = 1'b0;
		forever #2 iUsiClk = ~iUsiClk;
	end

	//----------------------------------------------------------------------
	// Reporting and bus helpers, all called on a falling edge
	//----------------------------------------------------------------------
	task automatic stopOnFailure();
		$display("SOME TESTS FAILED");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic checkEq(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("[ERROR] time %0d ns: %s is 0x%08h, expected 0x%08h",
				$time, what, got, exp);
			stopOnFailure();
		end
	endtask

	// Puts a command on the master port without waiting
	task automatic setCmd(input usiCmdT cmd, input logic [7:0] block,
		input logic [15:0] csr, input logic [31:0] wd);
		mUsiCmd.wd         = wd;
		mUsiCmd.adrs.cmd   = cmd;
		mUsiCmd.adrs.rsv   = '0;
		mUsiCmd.adrs.block = block;
		mUsiCmd.adrs.csr   = csr;
		mUsiCmd.wEd        = 1'b1;		// One cycle strobe
	endtask

	task automatic driveCmd(input usiCmdT cmd, input logic [7:0] block,
		input logic [15:0] csr, input logic [31:0] wd);
		setCmd(cmd, block, csr, wd);
		@(negedge iUsiClk);
		mUsiCmd.wEd = 1'b0;
	endtask

	task automatic busWrite(input logic [7:0] block, input logic [15:0] csr,
		input logic [31:0] wd);
		driveCmd(cmdWrite, block, csr, wd);
	endtask

	// Read word is on mUsiRd two cycles after the strobe
	task automatic busRead(input logic [7:0] block, input logic [15:0] csr,
		input logic [31:0] exp, input string what);
		driveCmd(cmdRead, block, csr, 32'h0);
		@(negedge iUsiClk);
		checkEq(what, mUsiRd, exp);
	endtask

	task automatic waitVd(input logic [1:0] mask, input logic [1:0] want,
		input int maxCycles, input string what);
		int n;
		n = 0;
		while ((mUsiVd & mask) != (want & mask))
		begin
			if (n >= maxCycles)
			begin
				$display("Timeout after %0d cycles waiting for %s, ready levels %b",
					maxCycles, what, mUsiVd);
				stopOnFailure();
			end
			@(negedge iUsiClk);
			n++;
		end
	endtask

	// Samples pwmOut on the given number of consecutive cycles
	task automatic countHigh(input int cycles, output int highs);
		highs = 0;
		repeat (cycles)
		begin
			if (pwmOut)
				highs++;
			@(negedge iUsiClk);
		end
	endtask

	// Disable, load period and duty directly, then enable
	task automatic pwmProgram(input int per, input int duty);
		busWrite(lpPwm, 16'd2, 32'h0);
		busWrite(lpPwm, 16'd0, 32'(per));
		busWrite(lpPwm, 16'd1, 32'(duty));
		busWrite(lpPwm, 16'd2, 32'h1);
		@(negedge iUsiClk);		// Enable now in effect
	endtask

	task automatic pwmCheck(input int per, input int duty, input string what);
		int highs;
		int expHigh;
		expHigh = (duty < per + 1) ? duty : per + 1;
		countHigh(per + 1, highs);
		checkEq(what, 32'(highs), 32'(expHigh));
	endtask

	//----------------------------------------------------------------------
	// Directed tests
	//----------------------------------------------------------------------
	task automatic resetTest();
		repeat (8)
		begin
			@(negedge iUsiClk);
			checkEq("ready levels in reset", 32'(mUsiVd), 32'h0);
			checkEq("gpioOut in reset", 32'(gpioOut), 32'h0);
			checkEq("gpioDir in reset", 32'(gpioDir), 32'h0);
			checkEq("pwmOut in reset", 32'(pwmOut), 32'h0);
		end
		rst = 1'b0;
		waitVd(2'b11, 2'b11, 10, "both slaves ready");
	endtask

	task automatic gpioTest();
		busWrite(lpGpio, 16'd0, 32'h0000_00a5);
		@(negedge iUsiClk);
		checkEq("gpioOut after write", 32'(gpioOut), 32'h0000_00a5);
		busWrite(lpGpio, 16'd2, 32'h0000_003c);
		@(negedge iUsiClk);
		checkEq("gpioDir after write", 32'(gpioDir), 32'h0000_003c);
		busRead(lpGpio, 16'd0, 32'h0000_00a5, "GPIO CSR 0 read");
		busRead(lpGpio, 16'd2, 32'h0000_003c, "GPIO CSR 2 read");
		busWrite(lpGpio, 16'd0, 32'hffff_ff5a);	// Bits above the pins dropped
		busRead(lpGpio, 16'd0, 32'h0000_005a, "GPIO CSR 0 wide write");
		gpioIn = 8'hc3;
		repeat (3) @(negedge iUsiClk);		// Through the synchronizer
		busRead(lpGpio, 16'd1, 32'h0000_00c3, "GPIO CSR 1 pins");
		busRead(lpGpio, 16'd9, 32'h0, "GPIO unknown CSR");
	endtask

	task automatic decodeTest();
		driveCmd(cmdNone, lpGpio, 16'd0, 32'hffff_ffff);
		driveCmd(cmdRead, lpGpio, 16'd0, 32'hffff_ffff);
		driveCmd(cmdWriteRead, lpGpio, 16'd2, 32'hffff_ffff);
		@(negedge iUsiClk);
		checkEq("gpioOut after non writes", 32'(gpioOut), 32'h0000_005a);
		checkEq("gpioDir after non writes", 32'(gpioDir), 32'h0000_003c);
		busRead(lpGpio, 16'd0, 32'h0000_005a, "GPIO CSR 0 after non writes");
		busRead(lpGpio, 16'd2, 32'h0000_003c, "GPIO CSR 2 after non writes");
		busRead(8'h07, 16'd0, `USI_BAD_READ, "unmapped block 7");
		busRead(8'h00, 16'd0, `USI_BAD_READ, "unmapped block 0");
	endtask

	task automatic pwmOutputTest();
		pwmProgram(9, 4);
		pwmCheck(9, 4, "PWM high count P 9 D 4");
		busRead(lpPwm, 16'd0, 32'd9, "PWM period read");
		busRead(lpPwm, 16'd1, 32'd4, "PWM duty read");
		pwmProgram(5, 20);
		pwmCheck(5, 20, "PWM high count, duty over period");
		pwmProgram(7, 0);
		pwmCheck(7, 0, "PWM high count, zero duty");
	endtask

	task automatic pwmShadowTest();
		int  n;
		logic prev;
		pwmProgram(9, 4);
		// Frame start is pwmOut rising, counter at 0 there
		n = 0;
		prev = pwmOut;
		@(negedge iUsiClk);
		while (!(prev == 1'b0 && pwmOut == 1'b1))
		begin
			if (n >= 30)
			begin
				$display("Timeout waiting for a PWM frame start");
				stopOnFailure();
			end
			prev = pwmOut;
			@(negedge iUsiClk);
			n++;
		end
		busWrite(lpPwm, 16'd1, 32'd7);
		waitVd(2'b10, 2'b00, 4, "PWM ready low after duty write");
		waitVd(2'b10, 2'b10, 11, "PWM ready high after wrap");
		pwmCheck(9, 7, "PWM high count after shadow load");
	endtask

	// Back to back GPIO traffic against a register model
	task automatic randomTraffic();
		logic [31:0] r;
		logic [31:0] wd;
		logic [15:0] csr;
		logic [7:0]  outM;
		logic [7:0]  dirM;
		logic [7:0]  inM;
		logic [31:0] expQ [0:49];
		logic        rdQ [0:49];
		int          i;
		r = $random(seed);
		inM = r[7:0];
		gpioIn = inM;
		busWrite(lpGpio, 16'd0, 32'h0);
		busWrite(lpGpio, 16'd2, 32'h0);
		outM = 8'h00;
		dirM = 8'h00;
		repeat (3) @(negedge iUsiClk);
		for (i = 0; i < 52; i++)
		begin
			if (i >= 2 && rdQ[i-2])
				checkEq($sformatf("random read %0d", i - 2), mUsiRd, expQ[i-2]);
			if (i < 50)
			begin
				r = $random(seed);
				wd = $random(seed);
				csr = {14'h0, r[2:1]};		// CSR 3 is unknown
				rdQ[i] = !r[0];
				expQ[i] = 32'h0;
				if (r[0])
				begin
					if (csr == 16'd0)
						outM = wd[7:0];
					else if (csr == 16'd2)
						dirM = wd[7:0];
					setCmd(cmdWrite, lpGpio, csr, wd);
				end
				else
				begin
					case (csr)
						16'd0: expQ[i] = {24'h0, outM};
						16'd1: expQ[i] = {24'h0, inM};
						16'd2: expQ[i] = {24'h0, dirM};
						default: expQ[i] = 32'h0;
					endcase
					setCmd(cmdRead, lpGpio, csr, wd);
				end
			end
			else
				mUsiCmd.wEd = 1'b0;
			@(negedge iUsiClk);
		end
		checkEq("gpioOut after random traffic", 32'(gpioOut), {24'h0, outM});
		checkEq("gpioDir after random traffic", 32'(gpioDir), {24'h0, dirM});
	endtask

	//----------------------------------------------------------------------
	// Main sequence
	//----------------------------------------------------------------------
	initial
	begin
		rst     = 1'b1;
		mUsiCmd = '0;
		gpioIn  = '0;
		seed    = 32'h7634_e990;
		resetTest();
		gpioTest();
		decodeTest();
		pwmOutputTest();
		pwmShadowTest();
		randomTraffic();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== usiSubsystem.sv ====
// Peripheral subsystem top with the UltraSimple interconnect, GPIO and PWM
// The master drives mUsiCmd and reads mUsiRd two cycles after each strobe
`include "usi_consts.svh"
`default_nettype none

module usiSubsystem
(
	input  wire                          iUsiClk,
	input  wire                          rst,
	// Bus master port
	input  wire usiPkg::usiBusCmdT       mUsiCmd,
	output logic [`USI_DATA_BIT-1:0]     mUsiRd,
	output logic [`USI_SLAVE_NUM-1:0]    mUsiVd,	// Bit per slot
	// Pins
	input  wire  [`USI_GPIO_WIDTH-1:0]   gpioIn,
	output logic [`USI_GPIO_WIDTH-1:0]   gpioOut,
	output logic [`USI_GPIO_WIDTH-1:0]   gpioDir,
	output logic                         pwmOut
);

	import usiPkg::*;

	// Slots follow the block map
	localparam int lpGpioSlot = `USI_GPIO_MAP - 1;
	localparam int lpPwmSlot  = `USI_PWM_MAP - 1;

	usiBusCmdT                   sUsiCmd;	// Broadcast command
	usiSlaveRdT                  sUsiRd;	// Read words by slot
	logic [`USI_SLAVE_NUM-1:0]   sUsiVd;	// Ready levels by slot

	//------------------------------------------------------------------
	// Interconnect
	//------------------------------------------------------------------
	ultraSimpleInterface usi_i
	(
		.iUsiClk (iUsiClk),
		.rst     (rst),
		.mUsiCmd (mUsiCmd),
		.mUsiRd  (mUsiRd),
		.mUsiVd  (mUsiVd),
		.sUsiCmd (sUsiCmd),
		.sUsiRd  (sUsiRd),
		.sUsiVd  (sUsiVd)
	);

	//------------------------------------------------------------------
	// Slaves
	//------------------------------------------------------------------
	usiGpioCsr #(.pGpioWidth(`USI_GPIO_WIDTH)) gpio_i
	(
		.iUsiClk (iUsiClk),
		.rst     (rst),
		.sUsiCmd (sUsiCmd),
		.rd      (sUsiRd[lpGpioSlot]),
		.vd      (sUsiVd[lpGpioSlot]),
		.gpioIn  (gpioIn),
		.gpioOut (gpioOut),
		.gpioDir (gpioDir)
	);

	usiPwmCsr pwm_i
	(
		.iUsiClk (iUsiClk),
		.rst     (rst),
		.sUsiCmd (sUsiCmd),
		.rd      (sUsiRd[lpPwmSlot]),
		.vd      (sUsiVd[lpPwmSlot]),
		.pwmOut  (pwmOut)
	);

endmodule

`default_nettype wire

// ==== usiPwmCsr.sv ====
// PWM slave on the UltraSimple bus
// CSR 0 period, CSR 1 duty, CSR 2 bit 0 enable
// While enabled new period and duty wait in shadows until the counter wraps
`include "usi_consts.svh"
`default_nettype none

module usiPwmCsr
(
	input  wire                     iUsiClk,
	input  wire                     rst,
	input  wire usiPkg::usiBusCmdT  sUsiCmd,	// Broadcast command
	output logic [`USI_DATA_BIT-1:0] rd,		// Read word for this slot
	output logic                    vd,			// Low while a shadow load waits
	output logic                    pwmOut
);

	import usiPkg::*;

	localparam int lpCntBit = 16;		// Period and duty width

	//------------------------------------------------------------------
	// CSR map
	//------------------------------------------------------------------
	localparam logic [15:0] lpCsrPer  = 16'd0;
	localparam logic [15:0] lpCsrDuty = 16'd1;
	localparam logic [15:0] lpCsrEn   = 16'd2;

	logic                wrEn;			// Valid write to this block
	logic                wrPer;
	logic                wrDuty;
	logic [lpCntBit-1:0] perShadow;		// Last written period
	logic [lpCntBit-1:0] dutyShadow;	// Last written duty
	logic [lpCntBit-1:0] perNext;
	logic [lpCntBit-1:0] dutyNext;
	logic [lpCntBit-1:0] perAct;		// Period in use
	logic [lpCntBit-1:0] dutyAct;		// Duty in use
	logic [lpCntBit-1:0] count;
	logic                enable;
	logic                wrap;			// Last cycle of a frame
	logic                loadAct;		// Shadows move to active set
	logic                pending;		// Shadow differs from active
	logic                ready;			// Out of reset

	assign wrEn   = sUsiCmd.wEd && (sUsiCmd.adrs.block == `USI_PWM_MAP)
		&& (sUsiCmd.adrs.cmd == cmdWrite);
	assign wrPer  = wrEn && (sUsiCmd.adrs.csr == lpCsrPer);
	assign wrDuty = wrEn && (sUsiCmd.adrs.csr == lpCsrDuty);

	// Shadow contents after this edge
	assign perNext  = wrPer  ? sUsiCmd.wd[lpCntBit-1:0] : perShadow;
	assign dutyNext = wrDuty ? sUsiCmd.wd[lpCntBit-1:0] : dutyShadow;

	assign wrap    = enable && (count == perAct);
	assign loadAct = !enable || wrap;		// Disabled block loads at once

	//------------------------------------------------------------------
	// Registers and shadow load
	//------------------------------------------------------------------
	always_ff @(posedge iUsiClk)
	begin
		if (rst)
		begin
			perShadow  <= '0;
			dutyShadow <= '0;
			perAct     <= '0;
			dutyAct    <= '0;
			enable     <= 1'b0;
			pending    <= 1'b0;
			ready      <= 1'b0;
		end
		else
		begin
			ready      <= 1'b1;
			perShadow  <= perNext;
			dutyShadow <= dutyNext;
			if (wrEn && (sUsiCmd.adrs.csr == lpCsrEn))
				enable <= sUsiCmd.wd[0];
			if (loadAct)
			begin
				perAct  <= perNext;		// Counter is at 0 here
				dutyAct <= dutyNext;
				pending <= 1'b0;
			end
			else if (wrPer || wrDuty)
				pending <= 1'b1;		// Held until the wrap
		end
	end

	//------------------------------------------------------------------
	// Frame counter
	//------------------------------------------------------------------
	// Runs 0 to perAct, so perAct + 1 cycles per frame
	always_ff @(posedge iUsiClk)
	begin
		if (rst)
			count <= '0;
		else if (!enable || wrap)
			count <= '0;
		else
			count <= count + 16'd1;
	end

	// High for the first dutyAct counts, constant high when duty exceeds period
	assign pwmOut = enable && (count < dutyAct);

	assign vd = ready && !pending;

	//------------------------------------------------------------------
	// Read mux
	//------------------------------------------------------------------
	always_comb
	begin
		rd = '0;
		case (sUsiCmd.adrs.csr)
			lpCsrPer:  rd[lpCntBit-1:0] = perShadow;		// Written value
			lpCsrDuty: rd[lpCntBit-1:0] = dutyShadow;
			lpCsrEn:   rd[0] = enable;
			default:   rd = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== usiGpioCsr.sv ====
// GPIO slave on the UltraSimple bus
// CSR 0 output data, CSR 1 synchronized pin input, CSR 2 direction
// Direction bit high means the pin drives gpioOut
`include "usi_consts.svh"
`default_nettype none

module usiGpioCsr
#(
	parameter int pGpioWidth = `USI_GPIO_WIDTH	// Pin count, at most 32
)
(
	input  wire                     iUsiClk,
	input  wire                     rst,
	input  wire usiPkg::usiBusCmdT  sUsiCmd,	// Broadcast command
	output logic [`USI_DATA_BIT-1:0] rd,		// Read word for this slot
	output logic                    vd,			// Ready level
	input  wire  [pGpioWidth-1:0]   gpioIn,		// Asynchronous pins
	output logic [pGpioWidth-1:0]   gpioOut,
	output logic [pGpioWidth-1:0]   gpioDir
);

	import usiPkg::*;

	//------------------------------------------------------------------
	// CSR map
	//------------------------------------------------------------------
	localparam logic [15:0] lpCsrOut = 16'd0;
	localparam logic [15:0] lpCsrIn  = 16'd1;	// Read only
	localparam logic [15:0] lpCsrDir = 16'd2;

	logic                  blockSel;	// Command addressed to this block
	logic                  wrEn;		// Valid write to this block
	logic [pGpioWidth-1:0] inMeta;		// First synchronizer stage
	logic [pGpioWidth-1:0] inSync;		// Safe to read

	assign blockSel = sUsiCmd.wEd && (sUsiCmd.adrs.block == `USI_GPIO_MAP);
	assign wrEn     = blockSel && (sUsiCmd.adrs.cmd == cmdWrite);	// Only plain writes

	//------------------------------------------------------------------
	// Writable registers
	//------------------------------------------------------------------
	always_ff @(posedge iUsiClk)
	begin
		if (rst)
		begin
			gpioOut <= '0;
			gpioDir <= '0;		// All pins input after reset
		end
		else if (wrEn)
		begin
			case (sUsiCmd.adrs.csr)
				lpCsrOut: gpioOut <= sUsiCmd.wd[pGpioWidth-1:0];
				lpCsrDir: gpioDir <= sUsiCmd.wd[pGpioWidth-1:0];
				default: ;		// Unknown CSR ignored
			endcase
		end
	end

	// Two flop input synchronizer
	always_ff @(posedge iUsiClk)
	begin
		inMeta <= gpioIn;
		inSync <= inMeta;
	end

	// Ready from the first cycle after reset
	always_ff @(posedge iUsiClk)
	begin
		if (rst)
			vd <= 1'b0;
		else
			vd <= 1'b1;
	end

	//------------------------------------------------------------------
	// Read mux
	//------------------------------------------------------------------
	always_comb
	begin
		rd = '0;		// Upper bits and unknown CSRs read zero
		case (sUsiCmd.adrs.csr)
			lpCsrOut: rd[pGpioWidth-1:0] = gpioOut;
			lpCsrIn:  rd[pGpioWidth-1:0] = inSync;
			lpCsrDir: rd[pGpioWidth-1:0] = gpioDir;
			default:  rd = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== ultraSimpleInterface.sv ====
// UltraSimple bus interconnect between one master and the CSR slaves
// Broadcasts the registered master command to all slaves and returns
// the addressed slave's read word two cycles after the strobe
`include "usi_consts.svh"
`default_nettype none

module ultraSimpleInterface
(
	input  wire              iUsiClk,
	input  wire              rst,
	// Master side
	input  wire usiPkg::usiBusCmdT  mUsiCmd,	// Command and strobe from the master
	output logic [`USI_DATA_BIT-1:0]  mUsiRd,	// Read word of the last command
	output logic [`USI_SLAVE_NUM-1:0] mUsiVd,	// Ready level per slot
	// Slave side
	output usiPkg::usiBusCmdT       sUsiCmd,	// Broadcast to every slave
	input  wire usiPkg::usiSlaveRdT sUsiRd,		// One read word per slot
	input  wire [`USI_SLAVE_NUM-1:0] sUsiVd
);

	// Map value that lands in slot 0
	localparam logic [`USI_BLOCK_BIT-1:0] lpSlotBase = `USI_GPIO_MAP;

	logic [`USI_BLOCK_BIT-1:0] blockSel;	// Block of the broadcast command
	logic [`USI_DATA_BIT-1:0]  slotWord;	// Read word picked from the slots

	//------------------------------------------------------------------
	// Master to slave command stage
	//------------------------------------------------------------------
	always_ff @(posedge iUsiClk)
	begin
		sUsiCmd.wd   <= mUsiCmd.wd;
		sUsiCmd.adrs <= mUsiCmd.adrs;
		if (rst)
			sUsiCmd.wEd <= 1'b0;
		else
			sUsiCmd.wEd <= mUsiCmd.wEd;		// Slaves act on this strobe
	end

	//------------------------------------------------------------------
	// Slave to master ready stage
	//------------------------------------------------------------------
	always_ff @(posedge iUsiClk)
	begin
		if (rst)
			mUsiVd <= '0;
		else
			mUsiVd <= sUsiVd;		// One cycle behind the slaves
	end

	//------------------------------------------------------------------
	// Block decode
	//------------------------------------------------------------------
	// Uses the registered address so the read word belongs to the
	// command the slaves are decoding right now
	assign blockSel = sUsiCmd.adrs.block;

	always_comb
	begin
		slotWord = `USI_BAD_READ;		// Unmapped block
		for (int s = 0; s < `USI_SLAVE_NUM; s++)
		begin
			// Slot s serves block lpSlotBase + s
			if (blockSel == lpSlotBase + s[`USI_BLOCK_BIT-1:0])
				slotWord = sUsiRd[s];
		end
	end

	//------------------------------------------------------------------
	// Result stage
	//------------------------------------------------------------------
	// Captured once per command and held until the next one
	always_ff @(posedge iUsiClk)
	begin
		if (sUsiCmd.wEd)
			mUsiRd <= slotWord;
	end

endmodule

`default_nettype wire

// ==== usiPkg.sv ====
// Types for the UltraSimple bus
// Port lists name them as usiPkg::name and module bodies take a wildcard import
`include "usi_consts.svh"
`default_nettype none

package usiPkg;

	//------------------------------------------------------------------
	// Command field
	//------------------------------------------------------------------
	typedef enum logic [1:0]
	{
		cmdNone      = 2'd0,	// Idle slot
		cmdWrite     = 2'd1,
		cmdRead      = 2'd2,
		cmdWriteRead = 2'd3		// Not implemented, acts as no op
	} usiCmdT;

	//------------------------------------------------------------------
	// Address word
	//------------------------------------------------------------------
	typedef struct packed
	{
		usiCmdT                    cmd;		// Bits 31:30
		logic [5:0]                rsv;		// Unused
		logic [`USI_BLOCK_BIT-1:0] block;	// Bits 23:16 select the slave
		logic [15:0]               csr;		// Register inside the slave
	} usiAdrsT;

	// Full command as the master issues it and the slaves see it
	typedef struct packed
	{
		logic [`USI_DATA_BIT-1:0] wd;		// Write data
		usiAdrsT                  adrs;
		logic                     wEd;		// One cycle strobe
	} usiBusCmdT;

	// Read words of all slaves, slot 0 in the low word
	typedef logic [`USI_SLAVE_NUM-1:0][`USI_DATA_BIT-1:0] usiSlaveRdT;

endpackage

`default_nettype wire

// ==== usi_consts.svh ====
// Constants shared by the UltraSimple bus interconnect, its slaves and the testbench
// Include wherever bus words are sized or block addresses are decoded
`ifndef USI_CONSTS_SVH
`define USI_CONSTS_SVH

//----------------------------------------------------------------------
// Bus word widths
//----------------------------------------------------------------------
// Write and read data words
`define USI_DATA_BIT	32
// Address word with command, block and CSR fields
`define USI_ADRS_BIT	32
// Block address field inside the address word
`define USI_BLOCK_BIT	8

//----------------------------------------------------------------------
// Block map
//----------------------------------------------------------------------
// Slaves hung on the interconnect
`define USI_SLAVE_NUM	2
// Read vector slot of a block is its map value minus one
`define USI_GPIO_MAP	8'h01
`define USI_PWM_MAP		8'h02

// Returned for an unmapped block so decode bugs stand out
`define USI_BAD_READ	32'h1234_5678

// Default pin count of the GPIO block
`define USI_GPIO_WIDTH	8

`endif
